// ==== bench/dcache_assertions.sv ====
/*
  Protocol checks on the cache controller, bound into dcache_ctrl.
  Memory requests are levels held until the matching ready strobe.
*/
`timescale 1ns/1ps
`default_nettype none

module dcache_assertions (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    rd_req,
    input logic                    wr_req,
    input logic                    resp_valid,
    input dcache_pkg::mem_rsp_t    mem_rsp,
    input dcache_pkg::ctrl_state_e state
);
    import dcache_pkg::*;

    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_req && wr_req))
        else $error("rd_req and wr_req high together");

    a_resp_in_lookup: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> state == LOOKUP)
        else $error("resp_valid outside LOOKUP");

    a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req && !mem_rsp.rd_rdy |=> rd_req)
        else $error("rd_req dropped before rd_rdy");

    a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wr_req && !mem_rsp.wr_rdy |=> wr_req)
        else $error("wr_req dropped before wr_rdy");

endmodule

bind dcache_ctrl dcache_assertions u_assertions (
    .clk(clk), .rst_n(rst_n), .rd_req(rd_req), .wr_req(wr_req),
    .resp_valid(resp_valid), .mem_rsp(mem_rsp), .state(state)
);

`default_nettype wire

// ==== bench/dcache_tb.sv ====
/*
  Testbench for the two-way data cache, one request in flight at a time.
  Memory model answers line reads and write-backs after random delays.
  Shadow and memory start from a fill pattern of the word address.
  Addresses are built through the address union, so any header split works.
*/
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int TMO = 200;   // cycles allowed per wait

    logic        clk;
    logic        rst_n;
    cpu_req_t    cpu_req;
    logic        busy;
    logic        resp_valid;
    logic [31:0] rdata;
    mem_cmd_t    mem_cmd;
    mem_rsp_t    mem_rsp;

    logic [31:0] shadow [logic [31:0]];   // what the CPU should see
    logic [31:0] mem [logic [31:0]];      // backing store behind the cache
    logic [31:0] exp_q [$];
    logic        is_load_q [$];
    logic [`DC_TAG_W-1:0] tags [3] = '{24'h00_0a11, 24'h3c_0b22, 24'h7f_fc33};
    dc_addr_u    last_wb;
    dc_addr_u    req_line;   // line address of the request in flight
    int          errors, checks, tests, failed_tests, err_mark;
    int          resp_cnt, sent_cnt, rd_cnt, wb_cnt;
    bit          timed_out;

    dcache_top uut (.*);

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    function automatic logic [31:0] shadow_rd(input logic [31:0] a);
        return shadow.exists(a) ? shadow[a] : fill_word(a);
    endfunction

    function automatic logic [31:0] mem_rd(input logic [31:0] a);
        return mem.exists(a) ? mem[a] : fill_word(a);
    endfunction

    function automatic dc_line_t shadow_line(input logic [31:0] base);
        dc_line_t l;
        for (int w = 0; w < `DC_LINE_WORDS; w++) begin
            l[w] = shadow_rd(base + 32'(4 * w));
        end
        return l;
    endfunction

    function automatic logic [31:0] mk_addr(input int t, input int set, input int off);
        dc_addr_u a;
        a.f.tag    = tags[t];
        a.f.index  = set[`DC_INDEX_W-1:0];
        a.f.offset = off[`DC_OFFSET_W-1:0];
        return a.raw;
    endfunction

    // expected load result from the addressed word
    function automatic logic [31:0] exp_load(input logic [31:0] w, input logic [1:0] off,
                                             input load_type_e lt);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*off +: 8];
        h = off[1] ? w[31:16] : w[15:0];
        case (lt)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'h0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'h0, h};
            default: return w;
        endcase
    endfunction

    task automatic chk_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic chk_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    task automatic chk_line(input string name, input dc_line_t got, input dc_line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic chk_addr(input string name, input dc_addr_u got, input dc_addr_u exp);
        checks++;
        if (got.raw !== exp.raw) begin
            errors++;
            $display("ERR %0t %s got %h exp %h", $time, name, got.raw, exp.raw);
        end
    endtask

    task automatic timeout_hit(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors != err_mark) begin
            failed_tests++;
        end
        $display("test %0d %s: %s, %0d errors", tests, name,
                 (errors == err_mark) ? "ok" : "failed", errors - err_mark);
        err_mark = errors;
    endtask

    // one request and the wait for its response
    task automatic access(input logic op, input logic [31:0] a, input logic [3:0] strb,
                          input logic [31:0] wd, input load_type_e lt);
        logic [31:0] wa;
        logic [31:0] word;
        int          n;
        if (timed_out) begin
            return;
        end
        wa = {a[31:2], 2'b00};
        req_line.raw      = a;
        req_line.f.offset = '0;
        if (op) begin
            word = shadow_rd(wa);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    word[8*b +: 8] = wd[8*b +: 8];
                end
            end
            shadow[wa] = word;
        end
        exp_q.push_back(op ? 32'h0 : exp_load(shadow_rd(wa), a[1:0], lt));
        is_load_q.push_back(!op);
        sent_cnt++;
        @(posedge clk);
        cpu_req <= {1'b1, op, a, strb, wd, lt};
        n = 0;
        @(negedge clk);
        while (busy && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            timeout_hit("request acceptance");
            return;
        end
        @(posedge clk);   // accepting edge
        cpu_req.valid <= 1'b0;
        n = 0;
        while (resp_cnt != sent_cnt && n < TMO) begin
            @(posedge clk);
            n++;
        end
        if (resp_cnt != sent_cnt) begin
            timeout_hit("resp_valid");
        end
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin : compare
        logic [31:0] e;
        logic        ld;
        forever begin
            @(negedge clk);
            if (rst_n && resp_valid) begin
                if (exp_q.size() == 0) begin
                    $display("response at %0t with no request outstanding", $time);
                    errors++;
                end else begin
                    e  = exp_q.pop_front();
                    ld = is_load_q.pop_front();
                    if (ld) begin
                        chk_word("rdata", rdata, e);
                    end
                    chk_flag("busy", busy, !ld);   // only a store hit stalls
                    resp_cnt++;
                end
            end
        end
    end

    initial begin : mem_model
        dc_addr_u a;
        dc_line_t l;
        mem_rsp <= '0;
        forever begin
            @(negedge clk);
            if (mem_cmd.wr_req) begin
                a = mem_cmd.wr_addr;
                chk_line("wr_line", mem_cmd.wr_line, shadow_line(a.raw));
                for (int w = 0; w < `DC_LINE_WORDS; w++) begin
                    mem[a.raw + 32'(4 * w)] = mem_cmd.wr_line[w];
                end
                last_wb = a;
                wb_cnt++;
                repeat ($urandom_range(0, 3) + 1) @(posedge clk);
                mem_rsp.wr_rdy <= 1'b1;
                @(posedge clk);
                mem_rsp.wr_rdy <= 1'b0;
                repeat ($urandom_range(0, 3) + 1) @(posedge clk);
                mem_rsp.wr_done <= 1'b1;
                @(posedge clk);
                mem_rsp.wr_done <= 1'b0;
            end else if (mem_cmd.rd_req) begin
                a = mem_cmd.rd_addr;
                chk_addr("rd_addr", a, req_line);
                rd_cnt++;
                for (int w = 0; w < `DC_LINE_WORDS; w++) begin
                    l[w] = mem_rd(a.raw + 32'(4 * w));
                end
                repeat ($urandom_range(0, 3) + 1) @(posedge clk);
                mem_rsp.rd_rdy <= 1'b1;
                @(posedge clk);
                mem_rsp.rd_rdy <= 1'b0;
                repeat ($urandom_range(0, 3) + 1) @(posedge clk);
                mem_rsp.ret_line  <= l;
                mem_rsp.ret_valid <= 1'b1;
                @(posedge clk);
                mem_rsp.ret_valid <= 1'b0;
            end
        end
    end

    initial begin : main
        int          base_cnt;
        logic [31:0] a;
        load_type_e  lt;
        dc_addr_u    exp_wb;
        void'($urandom(89190));
        rst_n   <= 1'b0;
        cpu_req <= '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        access(1'b0, mk_addr(0, 3, 4), 4'h0, 32'h0, LW);
        report_test("clean refill");

        base_cnt = rd_cnt;
        for (int off = 0; off < 16; off++) begin
            access(1'b0, mk_addr(0, 3, off), 4'h0, 32'h0, LB);
            access(1'b0, mk_addr(0, 3, off), 4'h0, 32'h0, LBU);
            if (off % 2 == 0) begin
                access(1'b0, mk_addr(0, 3, off), 4'h0, 32'h0, LH);
                access(1'b0, mk_addr(0, 3, off), 4'h0, 32'h0, LHU);
            end
            if (off % 4 == 0) begin
                access(1'b0, mk_addr(0, 3, off), 4'h0, 32'h0, LW);
            end
        end
        if (rd_cnt != base_cnt) begin
            $display("loads to a resident line went to memory");
            errors++;
        end
        report_test("resident loads");

        access(1'b1, mk_addr(0, 3, 8), 4'b0110, 32'hdead_beef, LW);
        access(1'b0, mk_addr(0, 3, 8), 4'h0, 32'h0, LW);
        report_test("partial store");

        // A and B fill set 7 and C evicts A
        base_cnt = wb_cnt;
        access(1'b1, mk_addr(0, 7, 0), 4'hf, 32'h1111_aaaa, LW);
        access(1'b1, mk_addr(1, 7, 4), 4'hc, 32'h2222_bbbb, LW);
        access(1'b0, mk_addr(2, 7, 12), 4'h0, 32'h0, LW);
        if (wb_cnt != base_cnt + 1) begin
            $display("eviction of the dirty line gave %0d write-backs", wb_cnt - base_cnt);
            errors++;
        end
        exp_wb.raw = mk_addr(0, 7, 0);
        chk_addr("wr_addr", last_wb, exp_wb);
        report_test("lru eviction");

        for (int i = 0; i < 300; i++) begin
            a  = mk_addr($urandom_range(0, 2), $urandom_range(0, 3) * 4 + 1,
                         $urandom_range(0, 15));
            lt = load_type_e'($urandom_range(0, 4));
            if (lt == LH || lt == LHU) begin
                a[0] = 1'b0;
            end
            if (lt == LW) begin
                a[1:0] = 2'b00;
            end
            access($urandom_range(0, 1) == 1, a, 4'($urandom_range(0, 15)), $urandom, lt);
        end
        report_test("random mix");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dcache_top.f ====
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_ctrl.sv
rtl/dcache_tag_array.sv
rtl/dcache_data_array.sv
rtl/dcache_plru.sv
rtl/dcache_load_align.sv
rtl/dcache_top.sv
bench/dcache_assertions.sv
bench/dcache_tb.sv

// ==== rtl/dcache_consts.svh ====
/*
  Geometry of the two-way data cache, shared by RTL and bench.
  Tag, index and offset widths must add up to 32.
  The replacement logic assumes exactly two ways.
  A line is DC_LINE_WORDS words of 32 bits.
*/
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// associativity
`define DC_WAYS 2

`define DC_SETS 16       // small on purpose, sim only
`define DC_LINE_WORDS 4

// address split, 32 bits total
`define DC_OFFSET_W 4
`define DC_INDEX_W 4
`define DC_TAG_W 24

`endif

// ==== rtl/dcache_ctrl.sv ====
/*
  Miss handling FSM of the data cache.
  A dirty victim is written back as a whole line before the refill read.
  Memory ready and done strobes may be delayed for any number of cycles.
  resp_valid is only raised in LOOKUP, after a hit.
*/
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   lk_valid,
    input  logic                   lk_op,
    input  logic [`DC_WAYS-1:0]    hit_way,
    input  logic                   victim_dirty,
    input  dcache_pkg::mem_rsp_t   mem_rsp,
    output logic                   busy,
    output logic                   resp_valid,
    output logic                   rd_req,
    output logic                   wr_req,
    output logic                   refill_we,
    output logic                   store_we,
    output logic                   reread,
    output dcache_pkg::ctrl_state_e state
);
    import dcache_pkg::*;

    ctrl_state_e state_next;
    logic        lk_hit;
    logic        lk_miss;

    assign lk_hit  = (state == LOOKUP) && lk_valid && (|hit_way);
    assign lk_miss = (state == LOOKUP) && lk_valid && !(|hit_way);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LOOKUP;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            LOOKUP: begin
                if (lk_miss) begin
                    state_next = victim_dirty ? MISS_DIRTY : MISS_CLEAN;
                end
            end
            MISS_DIRTY: begin
                if (mem_rsp.wr_rdy) begin
                    state_next = WRITE_BACK;
                end
            end
            WRITE_BACK: begin
                if (mem_rsp.wr_done) begin
                    state_next = MISS_CLEAN;
                end
            end
            MISS_CLEAN: begin
                if (mem_rsp.rd_rdy) begin
                    state_next = REFILL;
                end
            end
            REFILL: begin
                if (mem_rsp.ret_valid) begin
                    state_next = REFILL_DONE;
                end
            end
            REFILL_DONE: state_next = LOOKUP;   // arrays reread the new line
            default:     state_next = LOOKUP;
        endcase
    end

    assign resp_valid = lk_hit;
    assign store_we   = lk_hit && lk_op;    // merged line written at end of lookup
    assign refill_we  = (state == REFILL) && mem_rsp.ret_valid;

    // hold the lookup index on the arrays until the refilled line is read back
    assign reread = (state != LOOKUP) || lk_miss;
    assign busy   = reread || store_we;

    assign wr_req = (state == MISS_DIRTY);
    assign rd_req = (state == MISS_CLEAN);

endmodule

`default_nettype wire

// ==== rtl/dcache_data_array.sv ====
/*
  Line storage for both ways, no reset.
  Both ways are read every cycle through a registered read.
  A store hit rewrites the whole hit line with the strobed bytes merged in.
*/
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_data_array (
    input  logic                    clk,
    input  logic [`DC_INDEX_W-1:0]  rd_index,
    input  logic [`DC_INDEX_W-1:0]  lk_index,
    input  logic [`DC_OFFSET_W-1:0] lk_offset,
    input  logic [`DC_WAYS-1:0]     hit_way,
    input  logic                    victim_way,
    input  logic                    refill_we,
    input  logic                    store_we,
    input  logic [3:0]              wstrb,
    input  logic [31:0]             wdata,
    input  dcache_pkg::dc_line_t    ret_line,
    output dcache_pkg::dc_line_t    hit_line,
    output dcache_pkg::dc_line_t    victim_line
);
    import dcache_pkg::*;

    dc_line_t    data_mem [`DC_WAYS][`DC_SETS];
    dc_line_t    rd_line [`DC_WAYS];
    dc_line_t    store_line;
    logic [31:0] old_word;

    assign hit_line    = hit_way[1] ? rd_line[1] : rd_line[0];   // two ways only
    assign victim_line = rd_line[victim_way];

    always_comb begin
        store_line = hit_line;
        old_word   = hit_line[lk_offset[`DC_OFFSET_W-1:2]];
        for (int b = 0; b < 4; b++) begin
            store_line[lk_offset[`DC_OFFSET_W-1:2]][8*b +: 8] =
                wstrb[b] ? wdata[8*b +: 8] : old_word[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            rd_line[w] <= data_mem[w][rd_index];
            if (refill_we && (victim_way == 1'(w))) begin
                data_mem[w][lk_index] <= ret_line;
            end else if (store_we && hit_way[w]) begin
                data_mem[w][lk_index] <= store_line;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dcache_load_align.sv ====
/*
  Load data alignment, combinational.
  Word picked by offset bits 3..2, then half or byte by bits 1..0.
  Misaligned halves are not detected.
*/
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_load_align (
    input  dcache_pkg::dc_line_t    hit_line,
    input  logic [`DC_OFFSET_W-1:0] lk_offset,
    input  dcache_pkg::load_type_e  load_type,
    output logic [31:0]             rdata
);
    import dcache_pkg::*;

    logic [31:0] word;
    logic [15:0] half;
    logic [7:0]  byte_sel;

    assign word = hit_line[lk_offset[`DC_OFFSET_W-1:2]];
    assign half = lk_offset[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (lk_offset[1:0])
            2'd0:    byte_sel = word[7:0];
            2'd1:    byte_sel = word[15:8];
            2'd2:    byte_sel = word[23:16];
            default: byte_sel = word[31:24];
        endcase
    end

    always_comb begin
        case (load_type)
            LH:      rdata = {{16{half[15]}}, half};
            LHU:     rdata = {16'h0, half};
            LB:      rdata = {{24{byte_sel[7]}}, byte_sel};
            LBU:     rdata = {24'h0, byte_sel};
            default: rdata = word;   // LW
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/dcache_pkg.sv ====
/*
  Types of the data cache: address view, CPU request, memory command and
  response, load type and controller states.
  Field widths come from the consts header.
*/
`default_nettype none

`include "dcache_consts.svh"

package dcache_pkg;

    typedef struct packed {
        logic [`DC_TAG_W-1:0]    tag;
        logic [`DC_INDEX_W-1:0]  index;
        logic [`DC_OFFSET_W-1:0] offset;
    } dc_addr_fields_t;

    // same 32 bits, seen raw or split
    typedef union packed {
        logic [31:0]     raw;
        dc_addr_fields_t f;
    } dc_addr_u;

    typedef logic [`DC_LINE_WORDS-1:0][31:0] dc_line_t;

    typedef enum logic [2:0] {LW, LH, LHU, LB, LBU} load_type_e;

    typedef struct packed {
        logic        valid;
        logic        op;         // 1 = store
        dc_addr_u    addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        load_type_e  load_type;
    } cpu_req_t;

    typedef struct packed {
        logic     rd_req;
        dc_addr_u rd_addr;
        logic     wr_req;
        dc_addr_u wr_addr;
        dc_line_t wr_line;
    } mem_cmd_t;

    typedef struct packed {
        logic     rd_rdy;
        logic     ret_valid;
        dc_line_t ret_line;
        logic     wr_rdy;
        logic     wr_done;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        LOOKUP, MISS_DIRTY, WRITE_BACK, MISS_CLEAN, REFILL, REFILL_DONE
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== rtl/dcache_plru.sv ====
/*
  One replacement bit per set, naming the less recently used way.
  Fixed to two ways. hit_way must be gated to real hits by the caller.
*/
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_plru (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`DC_INDEX_W-1:0] lk_index,
    input  logic [`DC_WAYS-1:0]    hit_way,
    input  logic                   refill_we,
    output logic                   victim_way
);
    logic [`DC_SETS-1:0] lru_r;

    assign victim_way = lru_r[lk_index];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_r <= '0;
        end else if (refill_we) begin
            lru_r[lk_index] <= ~victim_way;   // refilled way becomes MRU
        end else if (|hit_way) begin
            lru_r[lk_index] <= hit_way[0];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dcache_tag_array.sv ====
/*
  Tag, valid and dirty storage for both ways.
  Reads are registered: the index at an edge gives tags in the next cycle.
  Valid and dirty bits clear on reset, tags do not.
*/
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_tag_array (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`DC_INDEX_W-1:0] rd_index,
    input  logic [`DC_TAG_W-1:0]   lk_tag,
    input  logic [`DC_INDEX_W-1:0] lk_index,
    input  logic                   victim_way,
    input  logic                   refill_we,
    input  logic                   store_we,
    output logic [`DC_WAYS-1:0]    hit_way,
    output logic                   victim_dirty,
    output logic [`DC_TAG_W-1:0]   victim_tag
);
    logic [`DC_TAG_W-1:0]              tag_mem [`DC_WAYS][`DC_SETS];
    logic [`DC_TAG_W-1:0]              tag_q [`DC_WAYS];
    logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid_r;
    logic [`DC_WAYS-1:0][`DC_SETS-1:0] dirty_r;
    logic [`DC_WAYS-1:0]               valid_q;
    logic [`DC_WAYS-1:0]               dirty_q;

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            tag_q[w] <= tag_mem[w][rd_index];
            if (refill_we && (victim_way == 1'(w))) begin
                tag_mem[w][lk_index] <= lk_tag;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_r <= '0;
            dirty_r <= '0;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                valid_q[w] <= valid_r[w][rd_index];
                dirty_q[w] <= dirty_r[w][rd_index];
                if (refill_we && (victim_way == 1'(w))) begin
                    valid_r[w][lk_index] <= 1'b1;
                    dirty_r[w][lk_index] <= 1'b0;   // fresh line from memory
                end else if (store_we && hit_way[w]) begin
                    dirty_r[w][lk_index] <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_way[w] = valid_q[w] && (tag_q[w] == lk_tag);
        end
    end

    // an invalid victim never needs a write-back
    assign victim_dirty = valid_q[victim_way] && dirty_q[victim_way];
    assign victim_tag   = tag_q[victim_way];

endmodule

`default_nettype wire

// ==== rtl/dcache_top.sv ====
/*
  Two-way set-associative write-back data cache.
  Requests are level based: one is taken at an edge with valid high and busy low.
  CPU must hold cpu_req while busy. Load hits respond one cycle after acceptance.
  Memory side moves whole lines only.
*/
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  dcache_pkg::cpu_req_t cpu_req,
    output logic                 busy,
    output logic                 resp_valid,
    output logic [31:0]          rdata,
    output dcache_pkg::mem_cmd_t mem_cmd,
    input  dcache_pkg::mem_rsp_t mem_rsp
);
    import dcache_pkg::*;

    cpu_req_t               lk_req;
    logic [`DC_INDEX_W-1:0] rd_index;
    logic [`DC_WAYS-1:0]    hit_way;
    logic [`DC_WAYS-1:0]    plru_hit;
    logic                   victim_way;
    logic                   victim_dirty;
    logic [`DC_TAG_W-1:0]   victim_tag;
    dc_line_t               hit_line;
    dc_line_t               victim_line;
    logic                   rd_req;
    logic                   wr_req;
    logic                   refill_we;
    logic                   store_we;
    logic                   reread;

    // lookup request, dropped once answered
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lk_req <= '0;
        end else if (cpu_req.valid && !busy) begin
            lk_req <= cpu_req;
        end else if (resp_valid) begin
            lk_req.valid <= 1'b0;
        end
    end

    assign rd_index = reread ? lk_req.addr.f.index : cpu_req.addr.f.index;
    assign plru_hit = resp_valid ? hit_way : '0;

    always_comb begin
        mem_cmd.rd_req          = rd_req;
        mem_cmd.rd_addr.raw     = {lk_req.addr.raw[31:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
        mem_cmd.wr_req          = wr_req;
        mem_cmd.wr_addr.f.tag    = victim_tag;
        mem_cmd.wr_addr.f.index  = lk_req.addr.f.index;
        mem_cmd.wr_addr.f.offset = '0;
        mem_cmd.wr_line         = victim_line;
    end

    dcache_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .lk_valid(lk_req.valid), .lk_op(lk_req.op),
        .hit_way(hit_way), .victim_dirty(victim_dirty), .mem_rsp(mem_rsp),
        .busy(busy), .resp_valid(resp_valid), .rd_req(rd_req), .wr_req(wr_req),
        .refill_we(refill_we), .store_we(store_we), .reread(reread), .state()
    );

    dcache_tag_array u_tag (
        .clk(clk), .rst_n(rst_n), .rd_index(rd_index),
        .lk_tag(lk_req.addr.f.tag), .lk_index(lk_req.addr.f.index),
        .victim_way(victim_way), .refill_we(refill_we), .store_we(store_we),
        .hit_way(hit_way), .victim_dirty(victim_dirty), .victim_tag(victim_tag)
    );

    dcache_data_array u_data (
        .clk(clk), .rd_index(rd_index),
        .lk_index(lk_req.addr.f.index), .lk_offset(lk_req.addr.f.offset),
        .hit_way(hit_way), .victim_way(victim_way),
        .refill_we(refill_we), .store_we(store_we),
        .wstrb(lk_req.wstrb), .wdata(lk_req.wdata), .ret_line(mem_rsp.ret_line),
        .hit_line(hit_line), .victim_line(victim_line)
    );

    dcache_plru u_plru (
        .clk(clk), .rst_n(rst_n), .lk_index(lk_req.addr.f.index),
        .hit_way(plru_hit), .refill_we(refill_we), .victim_way(victim_way)
    );

    dcache_load_align u_align (
        .hit_line(hit_line), .lk_offset(lk_req.addr.f.offset),
        .load_type(lk_req.load_type), .rdata(rdata)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps --top-module dcache_tb \
    -f dcache_top.f -Mdir obj_dir -o dcache_sim > build.log 2>&1 ||
    { echo "build failed, see build.log"; exit 1; }

./obj_dir/dcache_sim > sim.log 2>&1

grep -qx '>>> PASS' sim.log && echo "simulation passed" ||
    { echo "simulation failed, see sim.log"; exit 1; }
